/* bench/ctrlstatus_props.sv */
`timescale 1ns/100ps

module ctrlstatus_props (
  input logic                clk_core,
  input logic                rst_core_n,
  input logic                flush_req_o,
  input ctrlstatus_pkg::word flush_target_o,
  input logic                ctrl_begin_irq_o,
  input logic                csr_req_valid_i,
  input logic                csr_req_ready_o,
  input logic                csr_rsp_valid_o
);

  import ctrlstatus_pkg::*;

  // Target must not move while the redirect is outstanding.
  a_target_stable: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    (flush_req_o && $past(flush_req_o)) |-> (flush_target_o == $past(flush_target_o)))
    else $error("flush_target_o changed while flush_req_o was held");

  a_no_irq_in_flush: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    !(ctrl_begin_irq_o && flush_req_o))
    else $error("ctrl_begin_irq_o high during a flush request");

  a_rsp_after_fire: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    (csr_req_valid_i && csr_req_ready_o) |=> csr_rsp_valid_o)
    else $error("no CSR response one cycle after an accepted request");

  a_rsp_only_after_fire: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    csr_rsp_valid_o |-> $past(csr_req_valid_i && csr_req_ready_o))
    else $error("CSR response without an accepted request");

endmodule

bind ctrlstatus ctrlstatus_props u_props (.*);

/* bench/ctrlstatus_tb.sv */
`timescale 1ns/100ps

module ctrlstatus_tb;

  import ctrlstatus_pkg::*;

  typedef enum logic [2:0] {K_CSR, K_TRAP, K_MRET, K_IRQ, K_MASK} kind_t;

  typedef struct {
    kind_t      kind;
    csr_op_t    op;
    csr_addr_t  addr;
    logic       rnd;   // Take write data from the LFSR.
    word        data;
    privilege_t mode;  // Mode expected after the row.
  } row_t;

  localparam int NUM_ROWS = 23;
  localparam word MTVEC_INIT = 32'h0000_0100;

  logic         clk_core = 1'b0;
  logic         rst_core_n;
  logic         irq_i;
  word          flush_target_o;
  logic         flush_req_o;
  logic         flush_ack_i = 1'b0;
  logic         ctrl_flush_begin_i;
  logic         ctrl_trap_i;
  logic [4:0]   ctrl_trap_cause_i;
  word          ctrl_trap_value_i;
  logic         ctrl_mret_i;
  word          ctrl_next_pc_i;
  logic         ctrl_commit_i;
  logic         ctrl_begin_irq_o;
  csr_req_t     csr_req_i;
  logic         csr_req_valid_i;
  logic         csr_req_ready_o;
  word          csr_rdata_o;
  logic         csr_rsp_valid_o;
  privilege_t   current_mode_o;

  logic [31:0]  lfsr_q = 32'h323a4d96;
  row_t         rows [NUM_ROWS];
  word          shadow [6];     // mstatus, mtvec, mscratch, mepc, mcause, mtval.
  privilege_t   mode_exp;

  ctrlstatus #(
    .MTVEC_RESET(MTVEC_INIT)
  ) u_dut (.*);

  always #4 clk_core = ~clk_core;

  // Pipeline side of the flush handshake.
  always @(posedge clk_core) begin
    if (!rst_core_n) flush_ack_i <= 1'b0;
    else if (flush_req_o) flush_ack_i <= 1'b1;
    else flush_ack_i <= 1'b0;
  end

  initial begin
    #((NUM_ROWS + 1) * 200 * 8);
    $display("watchdog expired before the test sequence completed");
    $display("*** FAILED ***");
    $fatal(1);
  end

  // Taps 32, 22, 2, 1.
  function automatic word take_bits(int n);
    word r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int csr_slot(csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:  return 0;
      CSR_MTVEC:    return 1;
      CSR_MSCRATCH: return 2;
      CSR_MEPC:     return 3;
      CSR_MCAUSE:   return 4;
      CSR_MTVAL:    return 5;
      default:      return -1;
    endcase
  endfunction

  // Bits that a register really keeps.
  function automatic word legalize(csr_addr_t addr, word v);
    word r;
    case (addr)
      CSR_MSTATUS: begin
        r = v & 32'h0000_0088;
        if (v[12:11] != 2'b00) r[12:11] = 2'b11;
      end
      CSR_MTVEC, CSR_MEPC: r = v & ~32'h3;
      CSR_MCAUSE:          r = {v[31], 26'd0, v[4:0]};
      default:             r = v;
    endcase
    return r;
  endfunction

  function automatic row_t make_row(kind_t kind, csr_op_t op, csr_addr_t addr,
                                    logic rnd, word data, privilege_t mode);
    row_t r;
    r.kind = kind;
    r.op   = op;
    r.addr = addr;
    r.rnd  = rnd;
    r.data = data;
    r.mode = mode;
    return r;
  endfunction

  task automatic fail_now(string what);
    $display("%0t: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(string name, word got, word exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_mode(string name, privilege_t got, privilege_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Returns the target once ack is seen, then waits until the FSM is back in RUN.
  task automatic wait_flush(output word target);
    int n;
    n = 0;
    do begin
      @(posedge clk_core);
      n++;
      if (n > 100) fail_now("flush request was never acknowledged");
    end while (!(flush_req_o && flush_ack_i));
    target = flush_target_o;
    n = 0;
    do begin
      @(posedge clk_core);
      n++;
      if (n > 100) fail_now("flush handshake did not return to idle");
    end while (flush_req_o || flush_ack_i);
    @(posedge clk_core);
  endtask

  task automatic csr_access(csr_op_t op, csr_addr_t addr, word wdata, output word rdata);
    int n;
    n = 0;
    @(posedge clk_core);
    csr_req_i.op    <= op;
    csr_req_i.addr  <= addr;
    csr_req_i.wdata <= wdata;
    csr_req_valid_i <= 1'b1;
    do begin
      @(posedge clk_core);
      n++;
      if (n > 50) fail_now("CSR request was never accepted");
    end while (!csr_req_ready_o);
    csr_req_valid_i <= 1'b0;
    @(posedge clk_core);
    if (!csr_rsp_valid_o) fail_now("no CSR response after an accepted request");
    rdata = csr_rdata_o;
  endtask

  // Trap entry for exceptions and interrupts alike.
  task automatic model_trap(logic intr, logic [4:0] code, word value, word pc);
    word ms;
    ms = shadow[0];
    shadow[0] = {19'd0, (mode_exp == USER_MODE) ? 2'b00 : 2'b11, 3'd0, ms[3], 7'd0};
    shadow[3] = pc & ~32'h3;
    shadow[4] = {intr, 26'd0, code};
    shadow[5] = intr ? 32'd0 : value;
  endtask

  task automatic run_row(row_t r);
    word data;
    word rdata;
    word old;
    word nv;
    word target;
    word pc;
    word value;
    word tmp;
    logic [4:0] cause;
    int slot;
    int n;
    case (r.kind)
      K_CSR: begin
        data = r.rnd ? take_bits(32) : r.data;
        csr_access(r.op, r.addr, data, rdata);
        slot = csr_slot(r.addr);
        old = (slot < 0) ? 32'd0 : shadow[slot];
        check_word($sformatf("csr_rdata_o[%h]", r.addr), rdata, old);
        if (slot >= 0 && r.op != CSR_READ) begin
          case (r.op)
            CSR_WRITE: nv = data;
            CSR_SET:   nv = old | data;
            default:   nv = old & ~data;
          endcase
          shadow[slot] = legalize(r.addr, nv);
        end
      end
      K_TRAP: begin
        tmp = take_bits(5);
        cause = tmp[4:0];
        value = take_bits(32);
        pc = take_bits(32);
        @(posedge clk_core);
        ctrl_trap_i        <= 1'b1;
        ctrl_trap_cause_i  <= cause;
        ctrl_trap_value_i  <= value;
        ctrl_next_pc_i     <= pc;
        ctrl_flush_begin_i <= 1'b1;
        @(posedge clk_core);
        ctrl_flush_begin_i <= 1'b0;
        wait_flush(target);
        ctrl_trap_i <= 1'b0;
        check_word("flush_target_o", target, shadow[1]);
        model_trap(1'b0, cause, value, pc);
      end
      K_MRET: begin
        @(posedge clk_core);
        ctrl_mret_i        <= 1'b1;
        ctrl_flush_begin_i <= 1'b1;
        @(posedge clk_core);
        ctrl_flush_begin_i <= 1'b0;
        wait_flush(target);
        ctrl_mret_i <= 1'b0;
        check_word("flush_target_o", target, shadow[3]);
        shadow[0] = {24'd0, 1'b1, 3'd0, shadow[0][7], 3'd0};
      end
      K_IRQ: begin
        pc = take_bits(32);
        n = 0;
        @(posedge clk_core);
        irq_i <= 1'b1;
        do begin
          @(posedge clk_core);
          n++;
          if (n > 20) fail_now("interrupt was not raised to the pipeline");
        end while (!ctrl_begin_irq_o);
        ctrl_commit_i  <= 1'b1;
        ctrl_next_pc_i <= pc;
        @(posedge clk_core);
        ctrl_commit_i <= 1'b0;
        wait_flush(target);
        irq_i <= 1'b0;
        check_word("flush_target_o", target, shadow[1]);
        model_trap(1'b1, IRQ_CAUSE_MEXT, 32'd0, pc);
      end
      default: begin
        @(posedge clk_core);
        irq_i <= 1'b1;
        repeat (20) begin
          @(posedge clk_core);
          if (ctrl_begin_irq_o) fail_now("masked interrupt reached the pipeline");
        end
        irq_i <= 1'b0;
      end
    endcase
    mode_exp = r.mode;
    check_mode("current_mode_o", current_mode_o, r.mode);
  endtask

  initial begin
    word boot_pc;
    word target;

    rows[0]  = make_row(K_CSR,  CSR_WRITE, CSR_MSCRATCH, 1'b1, 32'd0, MACHINE_MODE);
    rows[1]  = make_row(K_CSR,  CSR_SET,   CSR_MSCRATCH, 1'b1, 32'd0, MACHINE_MODE);
    rows[2]  = make_row(K_CSR,  CSR_CLEAR, CSR_MSCRATCH, 1'b1, 32'd0, MACHINE_MODE);
    rows[3]  = make_row(K_CSR,  CSR_SET,   CSR_MSCRATCH, 1'b0, 32'd0, MACHINE_MODE);
    rows[4]  = make_row(K_CSR,  CSR_CLEAR, CSR_MSCRATCH, 1'b0, 32'd0, MACHINE_MODE);
    rows[5]  = make_row(K_CSR,  CSR_READ,  CSR_MSCRATCH, 1'b0, 32'd0, MACHINE_MODE);
    rows[6]  = make_row(K_CSR,  CSR_WRITE, 12'h7c0,      1'b1, 32'd0, MACHINE_MODE);
    rows[7]  = make_row(K_CSR,  CSR_READ,  12'h7c0,      1'b0, 32'd0, MACHINE_MODE);
    rows[8]  = make_row(K_CSR,  CSR_WRITE, CSR_MTVEC,    1'b1, 32'd0, MACHINE_MODE);
    rows[9]  = make_row(K_CSR,  CSR_READ,  CSR_MTVEC,    1'b0, 32'd0, MACHINE_MODE);
    rows[10] = make_row(K_TRAP, CSR_READ,  12'h000,      1'b0, 32'd0, MACHINE_MODE);
    rows[11] = make_row(K_CSR,  CSR_READ,  CSR_MEPC,     1'b0, 32'd0, MACHINE_MODE);
    rows[12] = make_row(K_CSR,  CSR_READ,  CSR_MCAUSE,   1'b0, 32'd0, MACHINE_MODE);
    rows[13] = make_row(K_CSR,  CSR_READ,  CSR_MTVAL,    1'b0, 32'd0, MACHINE_MODE);
    rows[14] = make_row(K_CSR,  CSR_READ,  CSR_MSTATUS,  1'b0, 32'd0, MACHINE_MODE);
    rows[15] = make_row(K_CSR,  CSR_WRITE, CSR_MEPC,     1'b1, 32'd0, MACHINE_MODE);
    rows[16] = make_row(K_CSR,  CSR_SET,   CSR_MSTATUS,  1'b0, 32'h80, MACHINE_MODE);
    rows[17] = make_row(K_CSR,  CSR_CLEAR, CSR_MSTATUS,  1'b0, 32'h1800, MACHINE_MODE);
    rows[18] = make_row(K_MRET, CSR_READ,  12'h000,      1'b0, 32'd0, USER_MODE);
    rows[19] = make_row(K_CSR,  CSR_READ,  CSR_MSTATUS,  1'b0, 32'd0, USER_MODE);
    rows[20] = make_row(K_IRQ,  CSR_READ,  12'h000,      1'b0, 32'd0, MACHINE_MODE);
    rows[21] = make_row(K_CSR,  CSR_READ,  CSR_MCAUSE,   1'b0, 32'd0, MACHINE_MODE);
    rows[22] = make_row(K_MASK, CSR_READ,  12'h000,      1'b0, 32'd0, MACHINE_MODE);

    shadow[0] = 32'h0000_1800; // Reset mpp is machine.
    shadow[1] = MTVEC_INIT;
    shadow[2] = '0;
    shadow[3] = '0;
    shadow[4] = '0;
    shadow[5] = '0;
    mode_exp = MACHINE_MODE;

    boot_pc = take_bits(32);
    rst_core_n         = 1'b0;
    irq_i              = 1'b0;
    ctrl_flush_begin_i = 1'b0;
    ctrl_trap_i        = 1'b0;
    ctrl_trap_cause_i  = '0;
    ctrl_trap_value_i  = '0;
    ctrl_mret_i        = 1'b0;
    ctrl_next_pc_i     = boot_pc;
    ctrl_commit_i      = 1'b0;
    csr_req_i          = '0;
    csr_req_valid_i    = 1'b0;

    repeat (2) @(posedge clk_core);
    rst_core_n <= 1'b1;

    wait_flush(target);
    check_word("flush_target_o", target, boot_pc);
    check_mode("current_mode_o", current_mode_o, MACHINE_MODE);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end

    repeat (4) @(posedge clk_core);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ctrlstatus_tb \
  --Mdir obj_dir -o sim_ctrlstatus \
  -f src.f

./obj_dir/sim_ctrlstatus > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

/* src.f */
verilog/ctrlstatus_pkg.sv
verilog/csr_file.sv
verilog/trap_fsm.sv
verilog/ctrlstatus.sv
bench/ctrlstatus_props.sv
bench/ctrlstatus_tb.sv

/* verilog/csr_file.sv */
`timescale 1ns/100ps

module csr_file #(
  parameter ctrlstatus_pkg::word MTVEC_RESET = 32'h0000_0000
) (
  input  logic                         clk_core,
  input  logic                         rst_core_n,

  input  ctrlstatus_pkg::csr_req_t     csr_req_i,
  input  logic                         csr_req_valid_i,
  output logic                         csr_req_ready_o,
  output ctrlstatus_pkg::word          csr_rdata_o,
  output logic                         csr_rsp_valid_o,

  input  ctrlstatus_pkg::trap_update_t trap_upd_i,
  output ctrlstatus_pkg::csr_state_t   state_o
);

  import ctrlstatus_pkg::*;

  logic        mie_q;
  logic        mpie_q;
  privilege_t  mpp_q;
  logic [29:0] mtvec_base_q;
  word         mscratch_q;
  logic [29:0] mepc_q;
  logic        mcause_int_q;
  logic [4:0]  mcause_code_q;
  word         mtval_q;

  logic trap_busy;
  logic req_fire;
  logic req_write;
  word  old_value;
  word  new_value;

  logic rsp_valid_q;
  word  rdata_q;

  assign trap_busy = trap_upd_i.mie_we | trap_upd_i.mpie_we | trap_upd_i.mpp_we |
                     trap_upd_i.mepc_we | trap_upd_i.mcause_interrupt_we |
                     trap_upd_i.mcause_code_we | trap_upd_i.mtval_we;

  assign csr_req_ready_o = ~trap_busy; // Trap writes win.
  assign req_fire        = csr_req_valid_i & csr_req_ready_o;
  assign req_write       = req_fire & (csr_req_i.op != CSR_READ);

  always_comb begin
    case (csr_req_i.addr)
      CSR_MSTATUS:  old_value = {19'd0, mpp_q, 3'd0, mpie_q, 3'd0, mie_q, 3'd0};
      CSR_MTVEC:    old_value = {mtvec_base_q, 2'b00}; // Direct mode only.
      CSR_MSCRATCH: old_value = mscratch_q;
      CSR_MEPC:     old_value = {mepc_q, 2'b00};
      CSR_MCAUSE:   old_value = {mcause_int_q, 26'd0, mcause_code_q};
      CSR_MTVAL:    old_value = mtval_q;
      default:      old_value = '0;
    endcase
  end

  always_comb begin
    case (csr_req_i.op)
      CSR_WRITE: new_value = csr_req_i.wdata;
      CSR_SET:   new_value = old_value | csr_req_i.wdata;
      CSR_CLEAR: new_value = old_value & ~csr_req_i.wdata;
      default:   new_value = old_value;
    endcase
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      mie_q         <= 1'b0;
      mpie_q        <= 1'b0;
      mpp_q         <= MACHINE_MODE;
      mtvec_base_q  <= MTVEC_RESET[31:2];
      mscratch_q    <= '0;
      mepc_q        <= '0;
      mcause_int_q  <= 1'b0;
      mcause_code_q <= '0;
      mtval_q       <= '0;
    end else if (trap_busy) begin
      if (trap_upd_i.mie_we) mie_q <= trap_upd_i.mie;
      if (trap_upd_i.mpie_we) mpie_q <= trap_upd_i.mpie;
      if (trap_upd_i.mpp_we) mpp_q <= trap_upd_i.mpp;
      if (trap_upd_i.mepc_we) mepc_q <= trap_upd_i.mepc;
      if (trap_upd_i.mcause_interrupt_we) mcause_int_q <= trap_upd_i.mcause_interrupt;
      if (trap_upd_i.mcause_code_we) mcause_code_q <= trap_upd_i.mcause_code;
      if (trap_upd_i.mtval_we) mtval_q <= trap_upd_i.mtval;
    end else if (req_write) begin
      case (csr_req_i.addr)
        CSR_MSTATUS: begin
          mie_q  <= new_value[3];
          mpie_q <= new_value[7];
          // Only user and machine exist, anything else reads back as machine.
          mpp_q  <= (new_value[12:11] == 2'b00) ? USER_MODE : MACHINE_MODE;
        end
        CSR_MTVEC:    mtvec_base_q <= new_value[31:2];
        CSR_MSCRATCH: mscratch_q <= new_value;
        CSR_MEPC:     mepc_q <= new_value[31:2];
        CSR_MCAUSE: begin
          mcause_int_q  <= new_value[31];
          mcause_code_q <= new_value[4:0];
        end
        CSR_MTVAL:    mtval_q <= new_value;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_fire;
    end
  end

  always_ff @(posedge clk_core) begin
    if (req_fire) rdata_q <= old_value; // Value before the update.
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rdata_o     = rdata_q;

  assign state_o.mie        = mie_q;
  assign state_o.mpie       = mpie_q;
  assign state_o.mpp        = mpp_q;
  assign state_o.mtvec_base = mtvec_base_q;
  assign state_o.mepc       = {mepc_q, 2'b00};

endmodule

/* verilog/ctrlstatus.sv */
`timescale 1ns/100ps

module ctrlstatus #(
  parameter ctrlstatus_pkg::word MTVEC_RESET = 32'h0000_0000
) (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       irq_i,

  output ctrlstatus_pkg::word        flush_target_o,
  output logic                       flush_req_o,
  input  logic                       flush_ack_i,

  input  logic                       ctrl_flush_begin_i,
  input  logic                       ctrl_trap_i,
  input  logic [4:0]                 ctrl_trap_cause_i,
  input  ctrlstatus_pkg::word        ctrl_trap_value_i,
  input  logic                       ctrl_mret_i,
  input  ctrlstatus_pkg::word        ctrl_next_pc_i,
  input  logic                       ctrl_commit_i,
  output logic                       ctrl_begin_irq_o,

  input  ctrlstatus_pkg::csr_req_t   csr_req_i,
  input  logic                       csr_req_valid_i,
  output logic                       csr_req_ready_o,
  output ctrlstatus_pkg::word        csr_rdata_o,
  output logic                       csr_rsp_valid_o,

  output ctrlstatus_pkg::privilege_t current_mode_o
);

  import ctrlstatus_pkg::*;

  csr_state_t   csr_state;
  trap_update_t trap_upd;

  csr_file #(
    .MTVEC_RESET(MTVEC_RESET)
  ) u_csr_file (
    .clk_core       (clk_core),
    .rst_core_n     (rst_core_n),
    .csr_req_i      (csr_req_i),
    .csr_req_valid_i(csr_req_valid_i),
    .csr_req_ready_o(csr_req_ready_o),
    .csr_rdata_o    (csr_rdata_o),
    .csr_rsp_valid_o(csr_rsp_valid_o),
    .trap_upd_i     (trap_upd),
    .state_o        (csr_state)
  );

  trap_fsm u_trap_fsm (
    .clk_core          (clk_core),
    .rst_core_n        (rst_core_n),
    .irq_i             (irq_i),
    .flush_target_o    (flush_target_o),
    .flush_req_o       (flush_req_o),
    .flush_ack_i       (flush_ack_i),
    .ctrl_flush_begin_i(ctrl_flush_begin_i),
    .ctrl_trap_i       (ctrl_trap_i),
    .ctrl_trap_cause_i (ctrl_trap_cause_i),
    .ctrl_trap_value_i (ctrl_trap_value_i),
    .ctrl_mret_i       (ctrl_mret_i),
    .ctrl_next_pc_i    (ctrl_next_pc_i),
    .ctrl_commit_i     (ctrl_commit_i),
    .ctrl_begin_irq_o  (ctrl_begin_irq_o),
    .csr_i             (csr_state),
    .trap_upd_o        (trap_upd),
    .current_mode_o    (current_mode_o)
  );

endmodule

/* verilog/ctrlstatus_pkg.sv */
package ctrlstatus_pkg;

  typedef logic [31:0] word;

  typedef enum logic [1:0] {
    USER_MODE    = 2'd0,
    MACHINE_MODE = 2'd3
  } privilege_t;

  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;

  // Machine external interrupt.
  localparam logic [4:0] IRQ_CAUSE_MEXT = 5'd11;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  typedef struct packed {
    csr_addr_t addr;
    csr_op_t   op;
    word       wdata;
  } csr_req_t;

  // Register values the sequencer looks at.
  typedef struct packed {
    logic        mie;
    logic        mpie;
    privilege_t  mpp;
    logic [29:0] mtvec_base;
    word         mepc;
  } csr_state_t;

  typedef struct packed {
    logic        mie_we;
    logic        mie;
    logic        mpie_we;
    logic        mpie;
    logic        mpp_we;
    privilege_t  mpp;
    logic        mepc_we;
    logic [29:0] mepc;               // PC bits 31:2.
    logic        mcause_interrupt_we;
    logic        mcause_interrupt;
    logic        mcause_code_we;
    logic [4:0]  mcause_code;
    logic        mtval_we;
    word         mtval;
  } trap_update_t;

endpackage

/* verilog/trap_fsm.sv */
`timescale 1ns/100ps

module trap_fsm (
  input  logic                         clk_core,
  input  logic                         rst_core_n,
  input  logic                         irq_i,

  output ctrlstatus_pkg::word          flush_target_o,
  output logic                         flush_req_o,
  input  logic                         flush_ack_i,

  input  logic                         ctrl_flush_begin_i,
  input  logic                         ctrl_trap_i,
  input  logic [4:0]                   ctrl_trap_cause_i,
  input  ctrlstatus_pkg::word          ctrl_trap_value_i,
  input  logic                         ctrl_mret_i,
  input  ctrlstatus_pkg::word          ctrl_next_pc_i,
  input  logic                         ctrl_commit_i,
  output logic                         ctrl_begin_irq_o,

  input  ctrlstatus_pkg::csr_state_t   csr_i,
  output ctrlstatus_pkg::trap_update_t trap_upd_o,
  output ctrlstatus_pkg::privilege_t   current_mode_o
);

  import ctrlstatus_pkg::*;

  typedef enum logic [2:0] {
    SETTLE,
    FLUSH_ENTER,
    FLUSH_EXIT,
    RUN,
    IRQ_PENDING
  } fsm_state_t;

  fsm_state_t state_q, state_d;
  privilege_t mode_q, mode_d;

  logic irq_pending_q;
  logic take_irq_q;
  logic interrupt_enable;
  logic is_trap;
  logic is_mret;
  logic jump;
  word  jump_target;
  word  target_q;

  // Trap and mret qualifiers are only looked at while in SETTLE.
  assign is_trap = ctrl_trap_i | take_irq_q;
  assign is_mret = ctrl_mret_i & ~is_trap;

  always_comb begin
    case (mode_q)
      USER_MODE:    interrupt_enable = 1'b1; // Lower privilege, never masked.
      MACHINE_MODE: interrupt_enable = csr_i.mie;
      default:      interrupt_enable = 1'b0;
    endcase
  end

  always_comb begin
    if (is_trap) jump_target = {csr_i.mtvec_base, 2'b00};
    else if (is_mret) jump_target = csr_i.mepc;
    else jump_target = ctrl_next_pc_i;
  end

  always_comb begin
    state_d          = state_q;
    mode_d           = mode_q;
    jump             = 1'b0;
    flush_req_o      = 1'b0;
    ctrl_begin_irq_o = 1'b0;
    trap_upd_o       = '0;

    case (state_q)
      SETTLE: begin
        jump        = 1'b1;
        flush_req_o = 1'b1;
        state_d     = FLUSH_ENTER;
        if (is_trap) begin
          mode_d                         = MACHINE_MODE;
          trap_upd_o.mie_we              = 1'b1;
          trap_upd_o.mie                 = 1'b0;
          trap_upd_o.mpie_we             = 1'b1;
          trap_upd_o.mpie                = csr_i.mie;
          trap_upd_o.mpp_we              = 1'b1;
          trap_upd_o.mpp                 = mode_q;
          trap_upd_o.mepc_we             = 1'b1;
          trap_upd_o.mepc                = ctrl_next_pc_i[31:2];
          trap_upd_o.mcause_interrupt_we = 1'b1;
          trap_upd_o.mcause_interrupt    = take_irq_q;
          trap_upd_o.mcause_code_we      = 1'b1;
          trap_upd_o.mcause_code = take_irq_q ? IRQ_CAUSE_MEXT : ctrl_trap_cause_i;
          trap_upd_o.mtval_we            = 1'b1;
          trap_upd_o.mtval       = take_irq_q ? '0 : ctrl_trap_value_i;
        end else if (is_mret) begin
          mode_d             = csr_i.mpp;
          trap_upd_o.mie_we  = 1'b1;
          trap_upd_o.mie     = csr_i.mpie;
          trap_upd_o.mpie_we = 1'b1;
          trap_upd_o.mpie    = 1'b1;
          trap_upd_o.mpp_we  = 1'b1;
          trap_upd_o.mpp     = USER_MODE;
        end
      end
      FLUSH_ENTER: begin
        flush_req_o = 1'b1;
        if (flush_ack_i) state_d = FLUSH_EXIT;
      end
      FLUSH_EXIT: begin
        if (!flush_ack_i) state_d = RUN;
      end
      RUN: begin
        if (ctrl_flush_begin_i) state_d = SETTLE;
        else if (irq_pending_q) state_d = IRQ_PENDING;
      end
      IRQ_PENDING: begin
        ctrl_begin_irq_o = 1'b1;
        if (ctrl_flush_begin_i | ctrl_commit_i) state_d = SETTLE;
      end
      default: state_d = SETTLE;
    endcase
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state_q       <= SETTLE; // Boot redirect.
      mode_q        <= MACHINE_MODE;
      irq_pending_q <= 1'b0;
      take_irq_q    <= 1'b0;
    end else begin
      state_q       <= state_d;
      mode_q        <= mode_d;
      irq_pending_q <= irq_i & interrupt_enable;
      // A flush in the same cycle as the commit cancels the interrupt.
      take_irq_q    <= ctrl_begin_irq_o & ctrl_commit_i & ~ctrl_flush_begin_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (jump) target_q <= jump_target;
  end

  // The target register loads at the same edge that enters FLUSH_ENTER.
  assign flush_target_o = (state_q == SETTLE) ? jump_target : target_q;
  assign current_mode_o = mode_q;

endmodule
